/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_move_gen_ctrl
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/chess_ctrl_pkg.sv */
`include "ctrl_settings.svh"

package chess_ctrl_pkg;

	typedef logic [255:0] board_state_t;                  // regs 2..9 side by side
	typedef logic [`ADDR_WIDTH-1:0] list_addr_t;          // ram word address
	typedef logic [`COUNT_WIDTH-1:0] count_t;             // moves in the list

	// ==================================================================
	// lmg side
	// ==================================================================

	// one fifo slot, msb first
	typedef struct packed {
		logic       invalid;    // slot carries no move
		logic [5:0] flags;      // piece / capture info, passed through
		logic [2:0] to_rank;
		logic [2:0] to_file;
		logic [2:0] from_rank;
		logic [2:0] from_file;
	} lmg_move_t;

	typedef lmg_move_t [`SLOTS_PER_WORD-1:0] lmg_fifo_word_t;   // slot 0 in low bits

	// ==================================================================
	// move list words as software sees them
	// ==================================================================

	typedef struct packed {
		logic [13:0] pad;
		logic [5:0]  flags;
		logic [2:0]  to_file;   // file before rank on this side
		logic [2:0]  to_rank;
		logic [2:0]  from_file;
		logic [2:0]  from_rank;
	} list_move_t;

	typedef struct packed {
		logic [`DATA_WIDTH-`COUNT_WIDTH-1:0] pad;
		count_t                              count;
	} list_count_t;

	// same ram word, read as a move entry or as the count word at COUNT_ADDR
	typedef union packed {
		list_move_t  move;
		list_count_t cnt;
	} list_word_u;

endpackage

/* hdl/ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// bus side
`define DATA_WIDTH 32          // bus and ram word
`define ADDR_WIDTH 15          // word address, 32768 words

// interface register map
`define REG_COUNT 16           // addresses 0..15 hit registers
`define CTRL_REG 0             // bit 0 start, bit 1 done
`define BOARD_REG_FIRST 2      // regs 2..9, reg 2 is the low word

// move list layout in ram
`define COUNT_ADDR 16          // number of moves written here
`define LIST_BASE 17           // first move entry

// lmg fifo word geometry
`define SLOTS_PER_WORD 8
`define SLOT_BITS 19           // invalid flag + 18 bit move

`define COUNT_WIDTH 8

`endif

/* hdl/mm_slave_regs.sv */
`include "ctrl_settings.svh"

module mm_slave_regs (
	input  logic                        clk,
	input  logic                        rst,
	input  chess_ctrl_pkg::list_addr_t  slave_address,
	input  logic                        slave_read,
	input  logic                        slave_write,
	input  logic [`DATA_WIDTH-1:0]      slave_writedata,
	output logic                        slave_waitrequest,
	input  logic                        done_set,        // pulse from the collector
	output logic                        start,
	output chess_ctrl_pkg::board_state_t board_state,
	output logic                        host_wr_valid,   // ram area write request
	output chess_ctrl_pkg::list_addr_t  host_wr_addr,
	output logic [`DATA_WIDTH-1:0]      host_wr_data,
	input  logic                        host_wr_ready,
	output logic [`DATA_WIDTH-1:0]      reg_rdata,
	output logic                        reg_hit          // last read was a register
);

	import chess_ctrl_pkg::*;

	localparam int REG_IDX_BITS = $clog2(`REG_COUNT);
	localparam int BOARD_WORDS = $bits(board_state_t) / `DATA_WIDTH;

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];   // interface registers
	logic                   reg_area;            // address below REG_COUNT
	logic [REG_IDX_BITS-1:0] reg_idx;
	logic                   ctrl_wr;             // host writes the control reg
	logic [`DATA_WIDTH-1:0] ctrl_next;

	// ==================================================================
	// address decode
	// ==================================================================
	assign reg_area = (slave_address < `REG_COUNT);
	assign reg_idx = slave_address[REG_IDX_BITS-1:0];
	assign ctrl_wr = slave_write && reg_area && (reg_idx == `CTRL_REG);

	assign start = regs[`CTRL_REG][0];

	// control word takes the host value but done stays with hardware
	always_comb begin
		ctrl_next = regs[`CTRL_REG];
		if (ctrl_wr) begin
			ctrl_next = slave_writedata;
			ctrl_next[1] = regs[`CTRL_REG][1];   // done is read only from the bus
		end
		if (done_set)
			ctrl_next[1] = 1'b1;                 // run finished
		if (!ctrl_next[0])
			ctrl_next[1] = 1'b0;                 // done needs start
	end

	// ==================================================================
	// register file
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else begin
			if (slave_write && reg_area && !ctrl_wr)
				regs[reg_idx] <= slave_writedata;   // plain data regs
			regs[`CTRL_REG] <= ctrl_next;
		end
	end

	// board words laid side by side with reg 2 lowest
	always_comb begin
		for (int i = 0; i < BOARD_WORDS; i++)
			board_state[i*`DATA_WIDTH +: `DATA_WIDTH] = regs[`BOARD_REG_FIRST + i];
	end

	// ==================================================================
	// read side
	// ==================================================================
	// register data is captured with the read and picked by the store next cycle
	always_ff @(posedge clk) begin
		if (slave_read)
			reg_rdata <= regs[reg_idx];
	end

	always_ff @(posedge clk) begin
		if (rst)
			reg_hit <= 1'b0;
		else
			reg_hit <= slave_read && reg_area;
	end

	// ram area writes go to the store and the bus stalls while the collector owns it
	assign host_wr_valid = slave_write && !reg_area;
	assign host_wr_addr = slave_address;
	assign host_wr_data = slave_writedata;
	assign slave_waitrequest = host_wr_valid && !host_wr_ready;

endmodule

/* hdl/move_collector.sv */
`include "ctrl_settings.svh"

module move_collector (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,          // control reg bit 0
	output logic                          lmg_reset,      // one cycle pulse
	input  logic                          lmg_done,
	output logic                          lmg_rden,       // one cycle pulse
	input  chess_ctrl_pkg::lmg_fifo_word_t lmg_fifo_word,  // valid the cycle after rden
	input  logic                          lmg_fifo_empty,
	output logic                          col_wr_en,
	output chess_ctrl_pkg::list_addr_t    col_wr_addr,
	output chess_ctrl_pkg::list_word_u    col_wr_data,
	output logic                          done_set
);

	import chess_ctrl_pkg::*;

	localparam int SLOT_IDX_BITS = $clog2(`SLOTS_PER_WORD);
	localparam logic [SLOT_IDX_BITS-1:0] LAST_SLOT = SLOT_IDX_BITS'(`SLOTS_PER_WORD - 1);

	// ==================================================================
	// FSM encodings
	// ==================================================================
	localparam logic [3:0] S_IDLE      = 4'd0;
	localparam logic [3:0] S_RESET     = 4'd1;   // lmg_reset high
	localparam logic [3:0] S_WAIT_DONE = 4'd2;   // lmg is searching
	localparam logic [3:0] S_RDEN      = 4'd3;   // pop one fifo word
	localparam logic [3:0] S_FETCH     = 4'd4;   // word arrives, capture it
	localparam logic [3:0] S_SLOT      = 4'd5;   // one slot per cycle
	localparam logic [3:0] S_COUNT     = 4'd6;   // count word at COUNT_ADDR
	localparam logic [3:0] S_TERM      = 4'd7;   // zero after last move
	localparam logic [3:0] S_DONE      = 4'd8;   // done_set pulse

	logic [3:0]               state;
	logic                     start_q;
	logic                     start_rise;
	logic [SLOT_IDX_BITS-1:0] slot_idx;      // slot under inspection
	count_t                   count;         // valid moves so far
	logic [`SLOTS_PER_WORD*`SLOT_BITS-1:0] word_q;   // captured fifo word
	lmg_move_t                cur_move;
	list_word_u               move_word;
	list_word_u               count_word;
	list_addr_t               move_addr;

	assign start_rise = start && !start_q;

	// slot select out of the held word
	assign cur_move = word_q[slot_idx*`SLOT_BITS +: `SLOT_BITS];

	// rank and file swap places for software
	always_comb begin
		move_word = '0;
		move_word.move.flags = cur_move.flags;
		move_word.move.to_file = cur_move.to_file;
		move_word.move.to_rank = cur_move.to_rank;
		move_word.move.from_file = cur_move.from_file;
		move_word.move.from_rank = cur_move.from_rank;
	end

	always_comb begin
		count_word = '0;
		count_word.cnt.count = count;
	end

	assign move_addr = list_addr_t'(`LIST_BASE) + list_addr_t'(count);   // next free entry

	// ==================================================================
	// outputs, decoded from state
	// ==================================================================
	assign lmg_reset = (state == S_RESET);
	assign lmg_rden = (state == S_RDEN);
	assign done_set = (state == S_DONE);

	always_comb begin
		col_wr_en = 1'b0;
		col_wr_addr = move_addr;
		col_wr_data = '0;                    // terminator by default
		case (state)
			S_SLOT: begin
				col_wr_en = !cur_move.invalid;   // invalid slots are skipped
				col_wr_data = move_word;
			end
			S_COUNT: begin
				col_wr_en = 1'b1;
				col_wr_addr = list_addr_t'(`COUNT_ADDR);
				col_wr_data = count_word;
			end
			S_TERM: col_wr_en = 1'b1;          // zero word right after the list
			default: col_wr_en = 1'b0;
		endcase
	end

	// ==================================================================
	// sequencer
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			start_q <= 1'b0;
			slot_idx <= '0;
			count <= '0;
		end else begin
			start_q <= start;
			if (!start) begin
				state <= S_IDLE;               // host dropped start, abandon run
			end else if (start_rise) begin
				state <= S_RESET;
				count <= '0;
			end else begin
				case (state)
					S_RESET: state <= S_WAIT_DONE;
					S_WAIT_DONE: if (lmg_done) state <= S_RDEN;
					S_RDEN: state <= S_FETCH;
					S_FETCH: begin
						state <= S_SLOT;
						slot_idx <= '0;
					end
					S_SLOT: begin
						if (!cur_move.invalid)
							count <= count + 1'b1;
						slot_idx <= slot_idx + 1'b1;
						if (slot_idx == LAST_SLOT)
							state <= lmg_fifo_empty ? S_COUNT : S_RDEN;   // more words or finish
					end
					S_COUNT: state <= S_TERM;
					S_TERM: state <= S_DONE;
					S_DONE: state <= S_IDLE;   // wait for the next start edge
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// word holder, loaded when the lmg presents data
	always_ff @(posedge clk) begin
		if (state == S_FETCH)
			word_q <= lmg_fifo_word;
	end

endmodule

/* hdl/move_gen_ctrl.sv */
`include "ctrl_settings.svh"

module move_gen_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	// avalon-mm slave
	input  chess_ctrl_pkg::list_addr_t    slave_address,
	input  logic                          slave_read,
	input  logic                          slave_write,
	input  logic [`DATA_WIDTH-1:0]        slave_writedata,
	output logic [`DATA_WIDTH-1:0]        slave_readdata,
	output logic                          slave_readdatavalid,
	output logic                          slave_waitrequest,
	// legal move generator
	output chess_ctrl_pkg::board_state_t  board_state,
	output logic                          lmg_reset,
	input  logic                          lmg_done,
	output logic                          lmg_rden,
	input  chess_ctrl_pkg::lmg_fifo_word_t lmg_fifo_word,
	input  logic                          lmg_fifo_empty
);

	import chess_ctrl_pkg::*;

	logic                   start;           // regs -> collector
	logic                   done_set;        // collector -> regs
	logic                   host_wr_valid;
	list_addr_t             host_wr_addr;
	logic [`DATA_WIDTH-1:0] host_wr_data;
	logic                   host_wr_ready;
	logic [`DATA_WIDTH-1:0] reg_rdata;
	logic                   reg_hit;
	logic                   col_wr_en;
	list_addr_t             col_wr_addr;
	list_word_u             col_wr_data;

	// ==================================================================
	// bus registers
	// ==================================================================
	mm_slave_regs u_regs (
		.clk               (clk),
		.rst               (rst),
		.slave_address     (slave_address),
		.slave_read        (slave_read),
		.slave_write       (slave_write),
		.slave_writedata   (slave_writedata),
		.slave_waitrequest (slave_waitrequest),
		.done_set          (done_set),
		.start             (start),
		.board_state       (board_state),
		.host_wr_valid     (host_wr_valid),
		.host_wr_addr      (host_wr_addr),
		.host_wr_data      (host_wr_data),
		.host_wr_ready     (host_wr_ready),
		.reg_rdata         (reg_rdata),
		.reg_hit           (reg_hit)
	);

	// lmg sequencer
	move_collector u_collector (
		.clk            (clk),
		.rst            (rst),
		.start          (start),
		.lmg_reset      (lmg_reset),
		.lmg_done       (lmg_done),
		.lmg_rden       (lmg_rden),
		.lmg_fifo_word  (lmg_fifo_word),
		.lmg_fifo_empty (lmg_fifo_empty),
		.col_wr_en      (col_wr_en),
		.col_wr_addr    (col_wr_addr),
		.col_wr_data    (col_wr_data),
		.done_set       (done_set)
	);

	// move list ram and read mux
	move_list_store u_store (
		.clk                 (clk),
		.col_wr_en           (col_wr_en),
		.col_wr_addr         (col_wr_addr),
		.col_wr_data         (col_wr_data),
		.host_wr_valid       (host_wr_valid),
		.host_wr_addr        (host_wr_addr),
		.host_wr_data        (host_wr_data),
		.host_wr_ready       (host_wr_ready),
		.rd_en               (slave_read),
		.rd_addr             (slave_address),
		.reg_rdata           (reg_rdata),
		.reg_hit             (reg_hit),
		.slave_readdata      (slave_readdata),
		.slave_readdatavalid (slave_readdatavalid)
	);

endmodule

/* hdl/move_list_store.sv */
`include "ctrl_settings.svh"

module move_list_store (
	input  logic                       clk,
	input  logic                       col_wr_en,       // collector write has priority
	input  chess_ctrl_pkg::list_addr_t col_wr_addr,
	input  chess_ctrl_pkg::list_word_u col_wr_data,
	input  logic                       host_wr_valid,   // host ram area write
	input  chess_ctrl_pkg::list_addr_t host_wr_addr,
	input  logic [`DATA_WIDTH-1:0]     host_wr_data,
	output logic                       host_wr_ready,
	input  logic                       rd_en,
	input  chess_ctrl_pkg::list_addr_t rd_addr,
	input  logic [`DATA_WIDTH-1:0]     reg_rdata,       // already one cycle late
	input  logic                       reg_hit,
	output logic [`DATA_WIDTH-1:0]     slave_readdata,
	output logic                       slave_readdatavalid
);

	import chess_ctrl_pkg::*;

	localparam int DEPTH = 1 << `ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] mem [DEPTH];   // whole address space with the low words unused
	logic                   wr_en;
	list_addr_t             wr_addr;
	logic [`DATA_WIDTH-1:0] wr_data;
	logic [`DATA_WIDTH-1:0] ram_q;         // synchronous read data
	logic                   rd_valid_q;

	// ==================================================================
	// write merge
	// ==================================================================
	// the collector never stalls so the host waits on any collector write
	assign host_wr_ready = !col_wr_en;

	always_comb begin
		wr_en = col_wr_en || host_wr_valid;
		if (col_wr_en) begin
			wr_addr = col_wr_addr;
			wr_data = col_wr_data;
		end else begin
			wr_addr = host_wr_addr;
			wr_data = host_wr_data;
		end
	end

	// single write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// ==================================================================
	// read path
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rd_en)
			ram_q <= mem[rd_addr];      // old data on a same cycle write
	end

	// valid one cycle after the read strobe
	always_ff @(posedge clk) begin
		rd_valid_q <= rd_en;
	end

	assign slave_readdata = reg_hit ? reg_rdata : ram_q;   // register or ram word
	assign slave_readdatavalid = rd_valid_q;

endmodule

/* sim/lmg_model.sv */
module lmg_model (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 lmg_reset,      // starts a new search
	input  logic                                 lmg_rden,
	input  chess_ctrl_pkg::lmg_fifo_word_t [2:0] words,          // preset fifo contents
	input  logic [2:0]                           n_words,        // how many of them are used
	input  logic [7:0]                           search_cycles,  // busy time after reset
	output logic                                 lmg_done,
	output chess_ctrl_pkg::lmg_fifo_word_t       lmg_fifo_word,
	output logic                                 lmg_fifo_empty
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [2:0] rd_ptr;     // next word to pop
	logic [7:0] busy_cnt;   // cycles left in the search

	assign lmg_fifo_empty = (rd_ptr >= n_words);   // every preset word popped

	always_ff @(posedge clk) begin
		if (rst) begin
			lmg_done <= 1'b0;
			busy_cnt <= '0;
			rd_ptr <= '0;
			lmg_fifo_word <= '0;
		end else if (lmg_reset) begin
			lmg_done <= 1'b0;                   // search restarts
			busy_cnt <= search_cycles;
			rd_ptr <= '0;
		end else begin
			if (busy_cnt != 8'd0) begin
				busy_cnt <= busy_cnt - 1'b1;
				lmg_done <= (busy_cnt == 8'd1);  // level from here on
			end
			if (lmg_rden) begin
				lmg_fifo_word <= words[rd_ptr[1:0]];   // shows up one cycle later
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* sim/tb_move_gen_ctrl.sv */
`include "ctrl_settings.svh"

module tb_move_gen_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	import chess_ctrl_pkg::*;

	localparam int KIND_SKIP = 0;     // polling read, nothing compared
	localparam int KIND_WORD = 1;
	localparam int KIND_LIST = 2;
	localparam int KIND_COUNT = 3;
	localparam int WAIT_LIMIT = 100;  // cycles allowed for any one wait

	logic                   clk;
	logic                   rst;
	list_addr_t             slave_address;
	logic                   slave_read;
	logic                   slave_write;
	logic [`DATA_WIDTH-1:0] slave_writedata;
	logic [`DATA_WIDTH-1:0] slave_readdata;
	logic                   slave_readdatavalid;
	logic                   slave_waitrequest;
	board_state_t           board_state;
	logic                   lmg_reset;
	logic                   lmg_done;
	logic                   lmg_rden;
	lmg_fifo_word_t         lmg_fifo_word;
	logic                   lmg_fifo_empty;
	lmg_fifo_word_t [2:0]   lmg_words;       // handed to the model
	logic [2:0]             lmg_nwords;
	logic [7:0]             search_cycles;
	list_word_u             rd_word;         // bus word seen as a list entry

	integer                 seed;
	int                     reset_cycles;    // cycles with lmg_reset high
	int                     rden_cycles;     // cycles with lmg_rden high
	logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];   // last value written per register
	list_word_u             exp_list[$];           // valid moves in slot order
	logic [`DATA_WIDTH-1:0] exp_q[$];              // one entry per outstanding read
	int                     kind_q[$];
	string                  name_q[$];

	assign rd_word = slave_readdata;

	move_gen_ctrl dut (.*);

	lmg_model lmg (
		.clk, .rst, .lmg_reset, .lmg_rden,
		.words(lmg_words), .n_words(lmg_nwords), .search_cycles,
		.lmg_done, .lmg_fifo_word, .lmg_fifo_empty
	);

	always #10 clk = ~clk;

	// expected list entry with rank and file traded and the invalid flag dropped
	function automatic list_word_u reformat_move(input lmg_move_t m);
		return {14'd0, m.flags, m.to_file, m.to_rank, m.from_file, m.from_rank};
	endfunction

	// ==================================================================
	// error exit and compare tasks
	// ==================================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] exp,
			input logic [`DATA_WIDTH-1:0] act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_list(input string name, input list_word_u exp, input list_word_u act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_board(input string name, input board_state_t exp,
			input board_state_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	// ==================================================================
	// bus tasks drive inputs 1 ns after the rising edge
	// ==================================================================
	task automatic bus_write(input list_addr_t addr, input logic [`DATA_WIDTH-1:0] data);
		int waited;
		slave_address = addr;
		slave_writedata = data;
		slave_write = 1'b1;
		waited = 0;
		@(negedge clk);                             // waitrequest settled mid cycle
		while (slave_waitrequest) begin             // held while the collector writes
			if (waited == WAIT_LIMIT)
				abort_run("waitrequest stayed high, write never accepted");
			@(negedge clk);
			waited++;
		end
		@(posedge clk);                             // write taken here
		#1;
		slave_write = 1'b0;
	endtask

	task automatic bus_read(input list_addr_t addr, input logic [`DATA_WIDTH-1:0] exp,
			input int kind, input string name, output logic [`DATA_WIDTH-1:0] data);
		int waited;
		exp_q.push_back(exp);
		kind_q.push_back(kind);
		name_q.push_back(name);
		slave_address = addr;
		slave_read = 1'b1;
		@(posedge clk);
		#1;
		slave_read = 1'b0;
		waited = 0;
		while (!slave_readdatavalid) begin
			if (waited == WAIT_LIMIT)
				abort_run("no readdatavalid after a read");
			@(posedge clk);
			#1;
			waited++;
		end
		if (waited != 0)
			abort_run("readdatavalid came later than one cycle after the read");
		data = slave_readdata;
	endtask

	task automatic wait_rden();
		int waited;
		waited = 0;
		while (!lmg_rden) begin
			if (waited == WAIT_LIMIT)
				abort_run("the LMG FIFO was never read");
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	task automatic wait_done();
		logic [`DATA_WIDTH-1:0] ctrl;
		int polls;
		ctrl = '0;
		polls = 0;
		while (!ctrl[1]) begin                      // poll the control register
			if (polls == WAIT_LIMIT)
				abort_run("done bit never set after start");
			bus_read(`CTRL_REG, '0, KIND_SKIP, "poll", ctrl);
			polls++;
		end
	endtask

	// random slots with bit 18 of each draw as the invalid flag
	task automatic fill_words(input int n, input bit all_invalid);
		logic [31:0] rnd;
		lmg_move_t m;
		int w;
		int s;
		exp_list.delete();
		lmg_words = '0;
		for (w = 0; w < n; w++) begin
			for (s = 0; s < `SLOTS_PER_WORD; s++) begin
				rnd = $random(seed);
				m = rnd[`SLOT_BITS-1:0];
				if (all_invalid)
					m.invalid = 1'b1;
				lmg_words[w][s] = m;
				if (!m.invalid)
					exp_list.push_back(reformat_move(m));
			end
		end
	endtask

	// count word followed by the entries and the zero terminator
	task automatic check_move_list();
		logic [`DATA_WIDTH-1:0] rd;
		int i;
		bus_read(`COUNT_ADDR, 32'(exp_list.size()), KIND_COUNT, "move count", rd);
		for (i = 0; i < exp_list.size(); i++)
			bus_read(list_addr_t'(`LIST_BASE + i), exp_list[i], KIND_LIST,
				$sformatf("move %0d", i), rd);
		bus_read(list_addr_t'(`LIST_BASE + exp_list.size()), '0, KIND_WORD, "terminator", rd);
	endtask

	// ==================================================================
	// read checker sampling mid cycle
	// ==================================================================
	always @(negedge clk) begin
		if (slave_readdatavalid === 1'b1) begin
			if (kind_q.size() == 0) begin
				abort_run("readdatavalid with no read outstanding");
			end else begin
				case (kind_q[0])
					KIND_WORD: check_word(name_q[0], exp_q[0], slave_readdata);
					KIND_LIST: check_list(name_q[0], exp_q[0], rd_word);
					KIND_COUNT: check_count(name_q[0], exp_q[0][`COUNT_WIDTH-1:0],
						rd_word.cnt.count);
					default: ;                      // poll value goes back to the caller
				endcase
				void'(exp_q.pop_front());
				void'(kind_q.pop_front());
				void'(name_q.pop_front());
			end
		end
	end

	// lmg strobes counted mid cycle
	always @(negedge clk) begin
		if (lmg_reset === 1'b1)
			reset_cycles++;
		if (lmg_rden === 1'b1)
			rden_cycles++;
	end

	initial begin
		logic [`DATA_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0] host_val;
		int i;
		seed = 32'h947fbf67;
		reset_cycles = 0;
		rden_cycles = 0;
		clk = 1'b0;
		rst = 1'b1;
		slave_address = '0;
		slave_read = 1'b0;
		slave_write = 1'b0;
		slave_writedata = '0;
		lmg_words = '0;
		lmg_nwords = '0;
		search_cycles = 8'd12;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;

		// register readback with start and done low in the control word
		shadow[`CTRL_REG] = 32'ha5a5_5af0;
		bus_write(`CTRL_REG, shadow[`CTRL_REG]);
		for (i = 1; i < `REG_COUNT; i++) begin
			shadow[i] = $random(seed);
			bus_write(list_addr_t'(i), shadow[i]);
		end
		for (i = 0; i < `REG_COUNT; i++)
			bus_read(list_addr_t'(i), shadow[i], KIND_WORD, $sformatf("register %0d", i), rd);
		check_board("board_state", {shadow[9], shadow[8], shadow[7], shadow[6],
			shadow[5], shadow[4], shadow[3], shadow[2]}, board_state);   // reg 2 lowest

		// ram area while idle
		host_val = $random(seed);
		bus_write(15'd300, host_val);
		bus_read(15'd300, host_val, KIND_WORD, "ram write while idle", rd);

		// ==================================================================
		// run over three words with a host write in the slot phase
		// ==================================================================
		fill_words(3, 1'b0);
		lmg_nwords = 3'd3;
		bus_write(`CTRL_REG, 32'h1);
		wait_rden();
		repeat (2) @(posedge clk);
		#1;
		host_val = $random(seed);
		bus_write(15'd500, host_val);              // may wait behind a move write
		wait_done();
		check_word("lmg_reset cycles", 32'd1, 32'(reset_cycles));
		check_word("lmg_rden cycles", 32'd3, 32'(rden_cycles));
		check_move_list();
		bus_read(`CTRL_REG, 32'h3, KIND_WORD, "done after run", rd);
		bus_write(`CTRL_REG, 32'h0);
		bus_read(`CTRL_REG, 32'h0, KIND_WORD, "done cleared with start", rd);
		bus_read(15'd500, host_val, KIND_WORD, "ram write during run", rd);

		// every slot invalid gives an empty list
		fill_words(1, 1'b1);
		lmg_nwords = 3'd1;
		search_cycles = 8'd5;
		bus_write(`CTRL_REG, 32'h1);
		wait_done();
		check_word("lmg_reset cycles", 32'd2, 32'(reset_cycles));
		check_word("lmg_rden cycles", 32'd4, 32'(rden_cycles));
		check_move_list();

		@(negedge clk);                            // let the checker take the last word
		#1;
		if (kind_q.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abort_run("reads still outstanding at the end of the test");
		end
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/chess_ctrl_pkg.sv
hdl/mm_slave_regs.sv
hdl/move_collector.sv
hdl/move_list_store.sv
hdl/move_gen_ctrl.sv
sim/lmg_model.sv
sim/tb_move_gen_ctrl.sv
